// File: hw/bridge_pkg.sv
package bridge_pkg;

    localparam int unsigned addr_w = 16;
    localparam int unsigned data_w = 8;

    // One request beat on either bus.
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } bus_req_t;

    // Response beat, ack is a single-cycle pulse.
    typedef struct packed {
        logic              ack;
        logic              err;
        logic [data_w-1:0] rdata;
    } bus_rsp_t;

    // Bus A address map.
    localparam logic [addr_w-1:0] a_target1_base = 16'h0000;
    localparam logic [addr_w-1:0] a_target2_base = 16'h4000;
    localparam logic [addr_w-1:0] bridge_base    = 16'h8000;

    // Bridge window, split into three bus B regions.
    localparam int unsigned bridge_size0 = 4096;
    localparam int unsigned bridge_size1 = 2048;
    localparam int unsigned bridge_size2 = 4096;
    localparam int unsigned bridge_span  = bridge_size0 + bridge_size1 + bridge_size2;

    // Where each window region lands on bus B.
    localparam logic [addr_w-1:0] b_target0_base = 16'h8000;
    localparam logic [addr_w-1:0] b_target1_base = 16'h0000;
    localparam logic [addr_w-1:0] b_target2_base = 16'h4000;

    // Fixed transfer issued by the push button.
    localparam logic [addr_w-1:0] button_addr = 16'h8004;
    localparam logic [data_w-1:0] button_data = 8'hA5;

endpackage

// File: hw/button_sync.sv
`timescale 1ns/10ps

module button_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic btn_trigger,
    output logic trigger_pulse
);
    logic sync_ff1;
    logic sync_ff2;
    logic sync_prev;

    // Two flops for metastability and one more for the edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_ff1      <= 1'b0;
            sync_ff2      <= 1'b0;
            sync_prev     <= 1'b0;
            trigger_pulse <= 1'b0;
        end else begin
            sync_ff1      <= btn_trigger;
            sync_ff2      <= sync_ff1;
            sync_prev     <= sync_ff2;
            // Registered so the pulse lands three cycles after the press.
            trigger_pulse <= sync_ff2 & ~sync_prev;
        end
    end

endmodule

// File: hw/bus_initiator.sv
`timescale 1ns/10ps

module bus_initiator #(
    parameter logic [bridge_pkg::addr_w-1:0] INIT_ADDR = '0,
    parameter logic [bridge_pkg::data_w-1:0] INIT_DATA = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 trigger,
    output bridge_pkg::bus_req_t req,
    input  bridge_pkg::bus_rsp_t rsp
);
    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_read
    } state_t;

    state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (trigger) begin
                        state <= st_write;
                    end
                end
                st_write: begin
                    if (rsp.ack) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    if (rsp.ack) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Same address for the write and the read-back.
    always_comb begin
        req.valid = (state != st_idle);
        req.write = (state == st_write);
        req.addr  = INIT_ADDR;
        req.wdata = INIT_DATA;
    end

    // Acks only come back while a request is up.
    a_ack_while_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp.ack |-> req.valid
    );

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bridge_pkg::bus_req_t req_hi,
    input  bridge_pkg::bus_req_t req_lo,
    output bridge_pkg::bus_rsp_t rsp_hi,
    output bridge_pkg::bus_rsp_t rsp_lo,
    output bridge_pkg::bus_req_t bus_req,
    input  bridge_pkg::bus_rsp_t bus_rsp
);
    logic busy;
    logic owner_hi;
    logic grant_hi;

    // High side wins when the bus is free.
    assign grant_hi = busy ? owner_hi : req_hi.valid;

    assign bus_req = grant_hi ? req_hi : req_lo;
    assign rsp_hi  = grant_hi ? bus_rsp : '0;
    assign rsp_lo  = grant_hi ? '0 : bus_rsp;

    // Owner stays locked until its ack.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            owner_hi <= 1'b0;
        end else if (!busy) begin
            if (bus_req.valid && !bus_rsp.ack) begin
                busy     <= 1'b1;
                owner_hi <= grant_hi;
            end
        end else if (bus_rsp.ack) begin
            busy <= 1'b0;
        end
    end

    // Locked owner keeps its request up until the ack.
    a_owner_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        busy |-> bus_req.valid
    );

endmodule

// File: hw/addr_decoder.sv
`timescale 1ns/10ps

module addr_decoder #(
    parameter logic [bridge_pkg::addr_w-1:0] BASE0 = '0,
    parameter int unsigned                   SIZE0 = 1,
    parameter logic [bridge_pkg::addr_w-1:0] BASE1 = '0,
    parameter int unsigned                   SIZE1 = 1,
    parameter logic [bridge_pkg::addr_w-1:0] BASE2 = '0,
    parameter int unsigned                   SIZE2 = 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bridge_pkg::bus_req_t req,
    output bridge_pkg::bus_rsp_t rsp,
    output bridge_pkg::bus_req_t t_req [3],
    input  bridge_pkg::bus_rsp_t t_rsp [3]
);
    import bridge_pkg::*;

    logic [2:0] hit;
    logic       err_q;
    bus_rsp_t   sel_rsp;

    function automatic logic in_range(
        input logic [31:0] addr,
        input logic [31:0] base,
        input logic [31:0] size
    );
        return (addr >= base) && (addr < base + size);
    endfunction

    always_comb begin
        hit[0] = in_range(32'(req.addr), 32'(BASE0), SIZE0);
        hit[1] = in_range(32'(req.addr), 32'(BASE1), SIZE1);
        hit[2] = in_range(32'(req.addr), 32'(BASE2), SIZE2);
    end

    // Only the selected target sees valid.
    always_comb begin
        sel_rsp = '0;
        for (int i = 0; i < 3; i++) begin
            t_req[i]       = req;
            t_req[i].valid = req.valid & hit[i];
            if (hit[i]) begin
                sel_rsp = t_rsp[i];
            end
        end
    end

    // Unmapped access.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req.valid && (hit == 3'b000) && !err_q;
        end
    end

    assign rsp = err_q ? bus_rsp_t'{ack: 1'b1, err: 1'b1, rdata: '0} : sel_rsp;

endmodule

// File: hw/mem_target.sv
`timescale 1ns/10ps

module mem_target #(
    parameter int unsigned MEM_ADDR_BITS = 11
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bridge_pkg::bus_req_t req,
    output bridge_pkg::bus_rsp_t rsp
);
    import bridge_pkg::*;

    logic [data_w-1:0]        mem [2**MEM_ADDR_BITS];
    logic [data_w-1:0]        rdata_q;
    logic [MEM_ADDR_BITS-1:0] index;
    logic                     ack_q;
    logic                     take;

    assign index = req.addr[MEM_ADDR_BITS-1:0];

    // Valid is still high during the ack cycle.
    assign take = req.valid && !ack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (req.write) begin
                mem[index] <= req.wdata;
            end else begin
                rdata_q <= mem[index];
            end
        end
    end

    assign rsp = '{ack: ack_q, err: 1'b0, rdata: rdata_q};

    // The taken request is still presented unchanged when the ack goes out.
    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp.ack |-> req.valid && $stable(req)
    );

endmodule

// File: hw/bus_bridge.sv
`timescale 1ns/10ps

module bus_bridge #(
    parameter logic [bridge_pkg::addr_w-1:0] BASE    = '0,
    parameter int unsigned                   SIZE0   = 1,
    parameter int unsigned                   SIZE1   = 1,
    parameter int unsigned                   SIZE2   = 1,
    parameter logic [bridge_pkg::addr_w-1:0] B_BASE0 = '0,
    parameter logic [bridge_pkg::addr_w-1:0] B_BASE1 = '0,
    parameter logic [bridge_pkg::addr_w-1:0] B_BASE2 = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bridge_pkg::bus_req_t a_req,
    output bridge_pkg::bus_rsp_t a_rsp,
    output bridge_pkg::bus_req_t b_req,
    input  bridge_pkg::bus_rsp_t b_rsp,
    output logic [7:0]           last_write
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_resp
    } state_t;

    state_t            state;
    logic [31:0]       offset;
    logic [31:0]       b_addr_full;
    logic              b_valid_q;
    logic              b_write_q;
    logic [addr_w-1:0] b_addr_q;
    logic [data_w-1:0] b_wdata_q;
    logic              err_q;
    logic [data_w-1:0] rdata_q;

    // Window offset to bus B address.
    always_comb begin
        offset = 32'(a_req.addr) - 32'(BASE);
        if (offset < SIZE0) begin
            b_addr_full = 32'(B_BASE0) + offset;
        end else if (offset < SIZE0 + SIZE1) begin
            b_addr_full = 32'(B_BASE1) + offset - SIZE0;
        end else begin
            b_addr_full = 32'(B_BASE2) + offset - SIZE0 - SIZE1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            b_valid_q  <= 1'b0;
            last_write <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (a_req.valid) begin
                        state     <= st_busy;
                        b_valid_q <= 1'b1;
                    end
                end
                st_busy: begin
                    if (b_rsp.ack) begin
                        state     <= st_resp;
                        b_valid_q <= 1'b0;
                        if (b_write_q && !b_rsp.err) begin
                            last_write <= b_wdata_q;
                        end
                    end
                end
                // Bus A ack goes out here.
                st_resp: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && a_req.valid) begin
            b_write_q <= a_req.write;
            b_addr_q  <= addr_w'(b_addr_full);
            b_wdata_q <= a_req.wdata;
        end
        if (state == st_busy && b_rsp.ack) begin
            err_q   <= b_rsp.err;
            rdata_q <= b_rsp.rdata;
        end
    end

    assign b_req = '{valid: b_valid_q, write: b_write_q, addr: b_addr_q, wdata: b_wdata_q};
    assign a_rsp = '{ack: (state == st_resp), err: err_q, rdata: rdata_q};

    // Bus A decode only routes addresses inside the window.
    a_in_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        a_req.valid |-> offset < SIZE0 + SIZE1 + SIZE2
    );

endmodule

// File: hw/bridge_system_top.sv
`timescale 1ns/10ps

module bridge_system_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 btn_trigger,
    input  bridge_pkg::bus_req_t ext_req,
    output bridge_pkg::bus_rsp_t ext_rsp,
    output logic [7:0]           leds
);
    import bridge_pkg::*;

    localparam int unsigned a_mem_bits = 11;
    localparam int unsigned a_mem_size = 2**a_mem_bits;

    logic     btn_pulse;
    bus_req_t btn_req;
    bus_rsp_t btn_rsp;
    bus_req_t a_req;
    bus_rsp_t a_rsp;
    bus_req_t a_t_req [3];
    bus_rsp_t a_t_rsp [3];
    bus_req_t b_req;
    bus_rsp_t b_rsp;
    bus_req_t b_t_req [3];
    bus_rsp_t b_t_rsp [3];

    button_sync u_button_sync (
        .clk(clk),
        .rst_n(rst_n),
        .btn_trigger(btn_trigger),
        .trigger_pulse(btn_pulse)
    );

    bus_initiator #(
        .INIT_ADDR(button_addr),
        .INIT_DATA(button_data)
    ) u_bus_initiator (
        .clk(clk),
        .rst_n(rst_n),
        .trigger(btn_pulse),
        .req(btn_req),
        .rsp(btn_rsp)
    );

    // Button initiator has priority over the host port.
    bus_arbiter u_bus_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .req_hi(btn_req),
        .req_lo(ext_req),
        .rsp_hi(btn_rsp),
        .rsp_lo(ext_rsp),
        .bus_req(a_req),
        .bus_rsp(a_rsp)
    );

    addr_decoder #(
        .BASE0(a_target1_base),
        .SIZE0(a_mem_size),
        .BASE1(a_target2_base),
        .SIZE1(a_mem_size),
        .BASE2(bridge_base),
        .SIZE2(bridge_span)
    ) u_decoder_a (
        .clk(clk),
        .rst_n(rst_n),
        .req(a_req),
        .rsp(a_rsp),
        .t_req(a_t_req),
        .t_rsp(a_t_rsp)
    );

    mem_target #(.MEM_ADDR_BITS(a_mem_bits)) u_mem_a1 (
        .clk(clk),
        .rst_n(rst_n),
        .req(a_t_req[0]),
        .rsp(a_t_rsp[0])
    );

    mem_target #(.MEM_ADDR_BITS(a_mem_bits)) u_mem_a2 (
        .clk(clk),
        .rst_n(rst_n),
        .req(a_t_req[1]),
        .rsp(a_t_rsp[1])
    );

    bus_bridge #(
        .BASE(bridge_base),
        .SIZE0(bridge_size0),
        .SIZE1(bridge_size1),
        .SIZE2(bridge_size2),
        .B_BASE0(b_target0_base),
        .B_BASE1(b_target1_base),
        .B_BASE2(b_target2_base)
    ) u_bus_bridge (
        .clk(clk),
        .rst_n(rst_n),
        .a_req(a_t_req[2]),
        .a_rsp(a_t_rsp[2]),
        .b_req(b_req),
        .b_rsp(b_rsp),
        .last_write(leds)
    );

    addr_decoder #(
        .BASE0(b_target0_base),
        .SIZE0(bridge_size0),
        .BASE1(b_target1_base),
        .SIZE1(bridge_size1),
        .BASE2(b_target2_base),
        .SIZE2(bridge_size2)
    ) u_decoder_b (
        .clk(clk),
        .rst_n(rst_n),
        .req(b_req),
        .rsp(b_rsp),
        .t_req(b_t_req),
        .t_rsp(b_t_rsp)
    );

    mem_target #(.MEM_ADDR_BITS(12)) u_mem_b0 (
        .clk(clk),
        .rst_n(rst_n),
        .req(b_t_req[0]),
        .rsp(b_t_rsp[0])
    );

    mem_target #(.MEM_ADDR_BITS(11)) u_mem_b1 (
        .clk(clk),
        .rst_n(rst_n),
        .req(b_t_req[1]),
        .rsp(b_t_rsp[1])
    );

    mem_target #(.MEM_ADDR_BITS(12)) u_mem_b2 (
        .clk(clk),
        .rst_n(rst_n),
        .req(b_t_req[2]),
        .rsp(b_t_rsp[2])
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int unsigned PERIOD_NS = 40
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: tests/bridge_system_tb.sv
`timescale 1ns/10ps

module bridge_system_tb;
    import bridge_pkg::*;

    localparam int unsigned ack_limit   = 64;
    localparam int unsigned cycle_limit = 4000;
    localparam int unsigned local_count = 8;

    logic       clk;
    logic       rst_n;
    logic       btn_trigger;
    bus_req_t   ext_req;
    bus_rsp_t   ext_rsp;
    logic [7:0] leds;

    int unsigned assert_errors = 0;
    int unsigned timeouts = 0;
    int unsigned cycles;
    logic [31:0] rng_state;
    string       test_name;

    // Expected response of the access in flight.
    logic       chk_rsp;
    logic       chk_rdata;
    logic       exp_err;
    logic [7:0] exp_rdata;
    logic       chk_leds;
    logic [7:0] exp_leds;
    logic       chk_reset;

    logic [7:0]  sb [logic [15:0]];
    logic [15:0] addr_list [$];
    logic [15:0] bridge_addrs [6] = '{16'h8004, 16'h8FFF, 16'h9000, 16'h97FF, 16'h9800, 16'hA7FF};

    tb_clock #(.PERIOD_NS(40)) u_clock (
        .clk(clk)
    );

    bridge_system_top i_dut (
        .clk(clk),
        .rst_n(rst_n),
        .btn_trigger(btn_trigger),
        .ext_req(ext_req),
        .ext_rsp(ext_rsp),
        .leds(leds)
    );

    a_reset_state: assert property (
        @(posedge clk) disable iff (!rst_n)
        chk_reset |-> !ext_rsp.ack && leds == 8'h00
    ) else begin
        assert_errors++;
        $display("ERROR %s: expected ack 0 leds 00, actual ack %0b leds %h",
                 test_name, $sampled(ext_rsp.ack), $sampled(leds));
    end

    a_rsp_err: assert property (
        @(posedge clk) disable iff (!rst_n)
        chk_rsp && ext_rsp.ack |-> ext_rsp.err == exp_err
    ) else begin
        assert_errors++;
        $display("ERROR %s: expected err %0b, actual %0b",
                 test_name, exp_err, $sampled(ext_rsp.err));
    end

    a_rsp_rdata: assert property (
        @(posedge clk) disable iff (!rst_n)
        chk_rsp && chk_rdata && ext_rsp.ack |-> ext_rsp.rdata == exp_rdata
    ) else begin
        assert_errors++;
        $display("ERROR %s: expected rdata %h, actual %h",
                 test_name, exp_rdata, $sampled(ext_rsp.rdata));
    end

    a_leds: assert property (
        @(posedge clk) disable iff (!rst_n)
        chk_leds |-> leds == exp_leds
    ) else begin
        assert_errors++;
        $display("ERROR %s: expected leds %h, actual %h", test_name, exp_leds, $sampled(leds));
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One host transfer held through its ack cycle.
    task automatic access(input logic is_write, input logic [15:0] addr,
                          input logic [7:0] wdata, input logic want_err,
                          input logic [7:0] want_rdata, input logic check_rdata);
        int unsigned waited;
        waited    = 0;
        exp_err   = want_err;
        exp_rdata = want_rdata;
        chk_rdata = check_rdata;
        chk_rsp   = 1'b1;
        ext_req   = '{valid: 1'b1, write: is_write, addr: addr, wdata: wdata};
        @(negedge clk);
        while (!ext_rsp.ack && waited < ack_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!ext_rsp.ack) begin
            timeouts++;
            $display("%s: no ack within %0d cycles for address %h", test_name, ack_limit, addr);
        end
        @(negedge clk);
        ext_req = '0;
        chk_rsp = 1'b0;
    endtask

    task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
        access(1'b1, addr, data, 1'b0, 8'h00, 1'b0);
        sb[addr] = data;
    endtask

    task automatic read_byte(input logic [15:0] addr);
        access(1'b0, addr, 8'h00, 1'b0, sb[addr], 1'b1);
    endtask

    task automatic write_then_read(input logic [15:0] addr, input logic [7:0] data);
        write_byte(addr, data);
        read_byte(addr);
    endtask

    task automatic check_leds(input logic [7:0] value);
        exp_leds = value;
        chk_leds = 1'b1;
        @(negedge clk);
        chk_leds = 1'b0;
    endtask

    task automatic wait_leds(input logic [7:0] value);
        int unsigned waited;
        waited = 0;
        while (leds != value && waited < ack_limit) begin
            @(negedge clk);
            waited++;
        end
        if (leds != value) begin
            timeouts++;
            $display("%s: leds never reached %h", test_name, value);
        end
        check_leds(value);
    endtask

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped by timeout after %0d cycles", cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [15:0] addr;
        logic [7:0]  data;
        rst_n       = 1'b0;
        btn_trigger = 1'b0;
        ext_req     = '0;
        chk_rsp     = 1'b0;
        chk_rdata   = 1'b0;
        exp_err     = 1'b0;
        exp_rdata   = 8'h00;
        chk_leds    = 1'b0;
        exp_leds    = 8'h00;
        chk_reset   = 1'b0;
        rng_state   = 32'd27013;
        test_name   = "reset";
        repeat (5) @(negedge clk);
        rst_n     = 1'b1;
        chk_reset = 1'b1;
        repeat (3) @(negedge clk);
        chk_reset = 1'b0;

        test_name = "local";
        for (int i = 0; i < local_count; i++) begin
            rng_state = xorshift32(rng_state);
            addr = {5'b0, rng_state[10:0]};
            // Odd entries go to the second local memory.
            if (i % 2 == 1) begin
                addr = addr | 16'h4000;
            end
            write_byte(addr, rng_state[23:16]);
            addr_list.push_back(addr);
        end
        foreach (addr_list[i]) begin
            read_byte(addr_list[i]);
        end

        // Top bit clear keeps these apart from the button byte.
        test_name = "bridge";
        data      = 8'h00;
        for (int i = 0; i < 6; i++) begin
            rng_state = xorshift32(rng_state);
            data = {1'b0, 3'(i), rng_state[3:0]};
            write_byte(bridge_addrs[i], data);
        end
        check_leds(data);
        foreach (bridge_addrs[i]) begin
            read_byte(bridge_addrs[i]);
        end

        test_name = "unmapped";
        access(1'b1, 16'h2000, 8'h11, 1'b1, 8'h00, 1'b1);
        access(1'b0, 16'h2000, 8'h00, 1'b1, 8'h00, 1'b1);
        access(1'b1, 16'hC000, 8'h22, 1'b1, 8'h00, 1'b1);
        access(1'b0, 16'hC000, 8'h00, 1'b1, 8'h00, 1'b1);

        test_name   = "button";
        btn_trigger = 1'b1;
        repeat (4) @(negedge clk);
        btn_trigger = 1'b0;
        wait_leds(button_data);
        sb[button_addr] = button_data;
        read_byte(button_addr);

        test_name = "arbitration";
        write_then_read(16'h8FFF, 8'h3C);
        check_leds(8'h3C);
        rng_state = xorshift32(rng_state);
        addr = {5'b0, rng_state[10:0]};
        btn_trigger = 1'b1;
        // Lands in the cycle the button initiator raises its request.
        repeat (4) @(negedge clk);
        write_byte(addr, rng_state[31:24]);
        btn_trigger = 1'b0;
        read_byte(addr);
        wait_leds(button_data);

        $display("Errors: %0d assertion, %0d timeout", assert_errors, timeouts);
        if (assert_errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: bridge_system.f
hw/bridge_pkg.sv
hw/button_sync.sv
hw/bus_initiator.sv
hw/bus_arbiter.sv
hw/addr_decoder.sv
hw/mem_target.sv
hw/bus_bridge.sv
hw/bridge_system_top.sv
tests/tb_clock.sv
tests/bridge_system_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module bridge_system_tb \
    -f bridge_system.f \
    -Mdir obj_dir \
    -o bridge_system_sim

./obj_dir/bridge_system_sim | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
